/* tb.f */
+incdir+tb
common/cpu_pkg.sv
hdl/unified_mem.sv
fetch/fetch_stage.sv
decode/decoder.sv
decode/reg_file.sv
execute/execute_stage.sv
hdl/cpu_top.sv
tb/tb_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_top
FILELIST  := tb.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) tb/tb_tests.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tb/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// IN then OUT echoes the port
task automatic test_in_out();
    logic [DATA_W-1:0] v;
    new_prog();
    v = DATA_W'($urandom());
    @(posedge clk);
    in_port <= v;  // held as a level for the run
    emit(OP_IN, R0, R0);
    emit_out(R0);
    exp_q.push_back(v);
    end_prog();
    run_prog("in_out");
endtask

// r2 = a, then r2 op= b, then OUT r2
task automatic apply_alu(logic [OPCODE_W-1:0] op, logic [DATA_W-1:0] expv);
    emit(OP_MOV, R2, R0);
    emit(op, R2, R1);
    emit_out(R2);
    exp_q.push_back(expv);
endtask

task automatic test_alu_ops();
    logic [DATA_W-1:0] a, b;
    new_prog();
    a = DATA_W'($urandom());
    b = DATA_W'($urandom());
    ldi(R0, a);
    ldi(R1, b);
    apply_alu(OP_ADD, a + b);  // wraps at 8 bits
    apply_alu(OP_SUB, a - b);
    apply_alu(OP_AND, a & b);
    apply_alu(OP_OR, a | b);
    apply_alu(OP_NOT, ~b);     // NOT reads rb only
    apply_alu(OP_MOV, b);
    end_prog();
    run_prog("alu_ops");
endtask

// every instruction reads the one just ahead of it
task automatic test_back_to_back();
    logic [DATA_W-1:0] x, y, s, d;
    new_prog();
    x = DATA_W'($urandom());
    y = DATA_W'($urandom());
    s = x + y;
    d = s + s;
    ldi(R0, x);
    ldi(R1, y);
    emit(OP_ADD, R0, R1);  // uses LDI write of the slot before
    emit(OP_ADD, R0, R0);
    emit(OP_MOV, R2, R0);
    emit(OP_OR, R2, R1);
    emit_out(R2);
    emit_out(R0);
    exp_q.push_back(d | y);
    exp_q.push_back(d);
    end_prog();
    run_prog("back_to_back");
endtask

task automatic test_store_load();
    logic [DATA_W-1:0] v, addr;
    new_prog();
    v    = DATA_W'($urandom_range(1, 255));    // nonzero, differs from reset r2
    addr = DATA_W'($urandom_range(128, 255));  // above the code
    ldi(R0, v);
    ldi(R1, addr);
    emit(OP_STM, R0, R1);  // mem[r1] <- r0
    emit(OP_LDM, R2, R1);  // r2 <- mem[r1]
    emit_out(R2);
    exp_q.push_back(v);
    end_prog();
    run_prog("store_load");
endtask

task automatic test_branches();
    logic [DATA_W-1:0] k, one, two;
    int fix_z, fix_c, fix_n, fix_j;
    new_prog();
    k   = DATA_W'($urandom_range(1, 255));
    one = 8'd1;
    two = 8'd2;
    ldi(R0, k);
    ldi(R1, k);
    fix_z = prog.size();
    ldi(R3, '0);           // target patched once known
    emit(OP_SUB, R0, R1);  // equal, so Z and C set
    emit(OP_JZ, R0, R3);
    emit_out(R1);          // both flush slots
    emit_out(R1);
    prog[fix_z + 1] = DATA_W'(prog.size());
    emit_out(R1);
    exp_q.push_back(k);
    ldi(R0, one);
    ldi(R1, two);
    fix_c = prog.size();
    ldi(R3, '0);
    emit(OP_ADD, R0, R1);  // no carry out
    emit(OP_JC, R0, R3);   // falls through
    emit_out(R0);
    exp_q.push_back(one + two);
    fix_n = prog.size();
    ldi(R3, '0);
    emit(OP_SUB, R1, R0);  // 2 - 3 goes negative
    emit(OP_JN, R0, R3);
    emit_out(R0);
    emit_out(R0);
    prog[fix_n + 1] = DATA_W'(prog.size());
    emit_out(R1);
    exp_q.push_back(two - (one + two));
    fix_j = prog.size();
    ldi(R3, '0);
    emit(OP_JMP, R0, R3);
    emit_out(R0);
    emit_out(R0);
    prog[fix_j + 1] = DATA_W'(prog.size());
    emit_out(R0);
    exp_q.push_back(one + two);
    prog[fix_c + 1] = DATA_W'(prog.size() + 2);  // a wrong JC lands in the final loop
    end_prog();
    run_prog("branches");
endtask

`endif

/* tb/tb_top.sv */
module tb_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [REG_IDX_W-1:0] R0 = 2'd0;
    localparam logic [REG_IDX_W-1:0] R1 = 2'd1;
    localparam logic [REG_IDX_W-1:0] R2 = 2'd2;
    localparam logic [REG_IDX_W-1:0] R3 = 2'd3;   // reserved for jump targets
    localparam int RUN_TIMEOUT = 300;              // cycles per program

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] in_port, boot_addr, boot_data, out_port;
    logic              boot_we, out_strobe;

    logic [DATA_W-1:0] prog[$];   // boot image, index is the address
    logic [DATA_W-1:0] exp_q[$];  // expected out_port values in order

    cpu_top #(.MEM_WORDS(256), .RESET_PC('0)) DUT (
        .clk(clk), .rst_n(rst_n), .in_port(in_port),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
        .out_port(out_port), .out_strobe(out_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_data(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // opcode in the upper nibble, then ra, then rb
    function automatic logic [DATA_W-1:0] enc(logic [OPCODE_W-1:0] op,
                                             logic [REG_IDX_W-1:0] ra,
                                             logic [REG_IDX_W-1:0] rb);
        return {op, ra, rb};
    endfunction

    task automatic emit(logic [OPCODE_W-1:0] op, logic [REG_IDX_W-1:0] ra,
                        logic [REG_IDX_W-1:0] rb);
        prog.push_back(enc(op, ra, rb));
    endtask

    task automatic ldi(logic [REG_IDX_W-1:0] r, logic [DATA_W-1:0] val);
        emit(OP_LDI, r, R0);
        prog.push_back(val);  // operand word
    endtask

    task automatic emit_out(logic [REG_IDX_W-1:0] r);
        emit(OP_OUT, r, R0);
    endtask

    task automatic new_prog();
        prog.delete();
        exp_q.delete();
    endtask

    // park the core in a jump-to-self loop
    task automatic end_prog();
        ldi(R3, DATA_W'(prog.size() + 2));  // address of the JMP below
        emit(OP_JMP, R0, R3);
    endtask

    // boot under reset, release, then gather strobes and compare
    task automatic run_prog(string name);
        logic [DATA_W-1:0] got[$];
        int waited;
        int idle;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 10 || i < prog.size(); i++) begin
            if (i < prog.size()) begin
                boot_we   <= 1'b1;
                boot_addr <= DATA_W'(i);
                boot_data <= prog[i];
            end else begin
                boot_we <= 1'b0;
            end
            @(posedge clk);
        end
        boot_we <= 1'b0;
        @(negedge clk);
        check_data("out_port in reset", out_port, '0);
        check_data("out_strobe in reset", DATA_W'(out_strobe), '0);
        @(posedge clk);
        rst_n <= 1'b1;
        waited = 0;
        idle   = 0;
        while (idle < 20) begin
            @(negedge clk);
            if (got.size() >= exp_q.size())
                idle++;  // quiet window after the last expected strobe
            if (out_strobe)
                got.push_back(out_port);
            else
                check_data("out_port idle", out_port, '0);
            waited++;
            if (waited > RUN_TIMEOUT) begin
                $display("%s: timed out with %0d of %0d output strobes seen",
                         name, got.size(), exp_q.size());
                stop_on_failure();
            end
        end
        check_count({name, " strobe count"}, got.size(), exp_q.size());
        foreach (exp_q[i])
            check_data($sformatf("%s out_port[%0d]", name, i), got[i], exp_q[i]);
    endtask

    `include "tb_tests.svh"

    initial begin
        rst_n     = 1'b0;
        in_port   = '0;
        boot_we   = 1'b0;
        boot_addr = '0;
        boot_data = '0;
        void'($urandom(10));
        test_in_out();
        test_alu_ops();
        test_back_to_back();
        test_store_load();
        test_branches();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* hdl/cpu_top.sv */
module cpu_top import cpu_pkg::*; #(
    parameter int                MEM_WORDS = 256,
    parameter logic [DATA_W-1:0] RESET_PC  = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] in_port,
    input  logic              boot_we,     // boot load, honored only in reset
    input  logic [DATA_W-1:0] boot_addr,
    input  logic [DATA_W-1:0] boot_data,
    output logic [DATA_W-1:0] out_port,
    output logic              out_strobe
);

    instr_word_u fetch_word, id_word;
    logic [DATA_W-1:0] fetch_addr;

    // decode controls
    logic [ALU_OP_W-1:0]  alu_op;
    logic                 reg_we, use_imm, mem_read, mem_we, io_in, io_out, flag_en;
    logic [REG_IDX_W-1:0] wr_sel_idx;
    logic [DATA_W-1:0]    imm;
    logic [2:0]           br_type;

    logic [DATA_W-1:0]    ra_data, rb_data;  // operand reads
    logic                 wr_en;  // write-back from EX
    logic [REG_IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0]    wr_data;

    logic [DATA_W-1:0] data_addr, data_wdata, data_rdata;
    logic              data_we;
    logic              branch_taken;
    logic [DATA_W-1:0] branch_target;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n),
        .fetch_word(fetch_word),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .fetch_addr(fetch_addr), .id_word(id_word)
    );

    decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .id_word(id_word), .branch_taken(branch_taken),
        .alu_op(alu_op), .reg_we(reg_we), .wr_sel_idx(wr_sel_idx), .use_imm(use_imm),
        .imm(imm), .mem_read(mem_read), .mem_we(mem_we), .io_in(io_in), .io_out(io_out),
        .flag_en(flag_en), .br_type(br_type)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .ra_idx(id_word.fields.ra),  // operand fields straight from ID word
        .rb_idx(id_word.fields.rb),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .ra_data(ra_data), .rb_data(rb_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n),
        .alu_op(alu_op), .reg_we(reg_we), .wr_sel_idx(wr_sel_idx), .use_imm(use_imm),
        .imm(imm), .mem_read(mem_read), .mem_we(mem_we), .io_in(io_in), .io_out(io_out),
        .flag_en(flag_en), .br_type(br_type),
        .ra_data(ra_data), .rb_data(rb_data), .in_port(in_port), .data_rdata(data_rdata),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .out_port(out_port), .out_strobe(out_strobe)
    );

    unified_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .fetch_addr(fetch_addr), .fetch_word(fetch_word),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
        .data_rdata(data_rdata),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data)
    );

endmodule

/* execute/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [ALU_OP_W-1:0]  alu_op,
    input  logic                 reg_we,
    input  logic [REG_IDX_W-1:0] wr_sel_idx,
    input  logic                 use_imm,
    input  logic [DATA_W-1:0]    imm,
    input  logic                 mem_read,
    input  logic                 mem_we,
    input  logic                 io_in,
    input  logic                 io_out,
    input  logic                 flag_en,
    input  logic [2:0]           br_type,
    input  logic [DATA_W-1:0]    ra_data,
    input  logic [DATA_W-1:0]    rb_data,
    input  logic [DATA_W-1:0]    in_port,
    input  logic [DATA_W-1:0]    data_rdata,
    output logic [DATA_W-1:0]    data_addr,
    output logic [DATA_W-1:0]    data_wdata,
    output logic                 data_we,
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic [DATA_W-1:0]    wr_data,
    output logic                 branch_taken,
    output logic [DATA_W-1:0]    branch_target,
    output logic [DATA_W-1:0]    out_port,
    output logic                 out_strobe
);

    // ID/EX control
    logic       ex_reg_we, ex_use_imm, ex_mem_read, ex_mem_we;
    logic       ex_io_in, ex_io_out, ex_flag_en;
    logic [2:0] ex_br_type;
    // ID/EX payload
    logic [ALU_OP_W-1:0]  ex_alu_op;
    logic [REG_IDX_W-1:0] ex_wr_idx;
    logic [DATA_W-1:0]    ex_imm, ex_a, ex_b;

    logic [DATA_W-1:0] alu_res;
    logic [DATA_W:0]   sum;     // extra bit holds add carry
    logic              alu_c;
    logic [2:0]        flags;   // Z N C

    always_ff @(posedge clk) begin
        if (!rst_n || branch_taken) begin
            ex_reg_we   <= 1'b0;  // bubble, kills the slot behind a jump
            ex_use_imm  <= 1'b0;
            ex_mem_read <= 1'b0;
            ex_mem_we   <= 1'b0;
            ex_io_in    <= 1'b0;
            ex_io_out   <= 1'b0;
            ex_flag_en  <= 1'b0;
            ex_br_type  <= BR_NONE;
        end else begin
            ex_reg_we   <= reg_we;
            ex_use_imm  <= use_imm;
            ex_mem_read <= mem_read;
            ex_mem_we   <= mem_we;
            ex_io_in    <= io_in;
            ex_io_out   <= io_out;
            ex_flag_en  <= flag_en;
            ex_br_type  <= br_type;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op <= alu_op;
        ex_wr_idx <= wr_sel_idx;
        ex_imm    <= imm;
        ex_a      <= ra_data;
        ex_b      <= rb_data;
    end

    assign sum = {1'b0, ex_a} + {1'b0, ex_b};

    always_comb begin
        alu_c = 1'b0;
        case (ex_alu_op)
            ALU_ADD: begin
                alu_res = sum[DATA_W-1:0];
                alu_c   = sum[DATA_W];
            end
            ALU_SUB: begin
                alu_res = ex_a - ex_b;
                alu_c   = (ex_a >= ex_b);  // no borrow
            end
            ALU_AND: alu_res = ex_a & ex_b;
            ALU_OR:  alu_res = ex_a | ex_b;
            ALU_NOT: alu_res = ~ex_b;
            default: alu_res = ex_b;        // pass b for MOV
        endcase
    end

    // flag register, C only moves on arithmetic
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ex_flag_en) begin
            flags[FLAG_Z] <= (alu_res == '0);
            flags[FLAG_N] <= alu_res[DATA_W-1];
            if (ex_alu_op == ALU_ADD || ex_alu_op == ALU_SUB)
                flags[FLAG_C] <= alu_c;
        end
    end

    always_comb begin
        case (ex_br_type)
            BR_Z:      branch_taken = flags[FLAG_Z];
            BR_N:      branch_taken = flags[FLAG_N];
            BR_C:      branch_taken = flags[FLAG_C];
            BR_ALWAYS: branch_taken = 1'b1;
            default:   branch_taken = 1'b0;
        endcase
    end
    assign branch_target = ex_b;  // register-indirect target

    // memory port, address rb and store data ra
    assign data_addr  = ex_b;
    assign data_wdata = ex_a;
    assign data_we    = ex_mem_we;

    assign wr_en   = ex_reg_we;
    assign wr_idx  = ex_wr_idx;
    assign wr_data = ex_use_imm  ? ex_imm     :
                     ex_mem_read ? data_rdata :
                     ex_io_in    ? in_port    : alu_res;

    // output port is zero except in the strobe cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_port   <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_port   <= ex_io_out ? ex_a : '0;
            out_strobe <= ex_io_out;
        end
    end

endmodule

/* decode/reg_file.sv */
module reg_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] ra_idx,
    input  logic [REG_IDX_W-1:0] rb_idx,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]    wr_data,
    output logic [DATA_W-1:0]    ra_data,
    output logic [DATA_W-1:0]    rb_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // bypass the EX write into the same-cycle read, so no forwarding is needed
    assign ra_data = (wr_en && wr_idx == ra_idx) ? wr_data : regs[ra_idx];
    assign rb_data = (wr_en && wr_idx == rb_idx) ? wr_data : regs[rb_idx];

endmodule

/* decode/decoder.sv */
module decoder import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  instr_word_u          id_word,
    input  logic                 branch_taken,
    output logic [ALU_OP_W-1:0]  alu_op,
    output logic                 reg_we,
    output logic [REG_IDX_W-1:0] wr_sel_idx,
    output logic                 use_imm,     // write-back takes imm
    output logic [DATA_W-1:0]    imm,
    output logic                 mem_read,
    output logic                 mem_we,
    output logic                 io_in,
    output logic                 io_out,
    output logic                 flag_en,
    output logic [2:0]           br_type
);

    logic                 imm_pending;  // second LDI word is in ID
    logic [REG_IDX_W-1:0] imm_idx;      // LDI destination, held one cycle

    // operand view of the same word
    assign imm = id_word.imm;

    always_comb begin
        alu_op     = ALU_PASS_B;
        reg_we     = 1'b0;
        wr_sel_idx = id_word.fields.ra;  // ra is always the destination
        use_imm    = 1'b0;
        mem_read   = 1'b0;
        mem_we     = 1'b0;
        io_in      = 1'b0;
        io_out     = 1'b0;
        flag_en    = 1'b0;
        br_type    = BR_NONE;
        if (imm_pending) begin
            reg_we     = 1'b1;  // the one write of LDI
            wr_sel_idx = imm_idx;
            use_imm    = 1'b1;
        end else begin
            case (id_word.fields.opcode)
                OP_MOV: reg_we = 1'b1;  // pass b, flags untouched
                OP_ADD: begin
                    alu_op  = ALU_ADD;
                    reg_we  = 1'b1;
                    flag_en = 1'b1;
                end
                OP_SUB: begin
                    alu_op  = ALU_SUB;
                    reg_we  = 1'b1;
                    flag_en = 1'b1;
                end
                OP_AND: begin
                    alu_op  = ALU_AND;
                    reg_we  = 1'b1;
                    flag_en = 1'b1;
                end
                OP_OR: begin
                    alu_op  = ALU_OR;
                    reg_we  = 1'b1;
                    flag_en = 1'b1;
                end
                OP_NOT: begin
                    alu_op  = ALU_NOT;
                    reg_we  = 1'b1;
                    flag_en = 1'b1;
                end
                OP_IN: begin
                    reg_we = 1'b1;
                    io_in  = 1'b1;
                end
                OP_OUT: io_out = 1'b1;
                OP_LDI: ;  // bubble now, write happens with next word
                OP_LDM: begin
                    reg_we   = 1'b1;
                    mem_read = 1'b1;
                end
                OP_STM: mem_we  = 1'b1;
                OP_JZ:  br_type = BR_Z;
                OP_JN:  br_type = BR_N;
                OP_JC:  br_type = BR_C;
                OP_JMP: br_type = BR_ALWAYS;
                default: ;  // NOP
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || branch_taken)
            imm_pending <= 1'b0;  // a flushed LDI never writes
        else
            imm_pending <= !imm_pending && (id_word.fields.opcode == OP_LDI);
    end

    always_ff @(posedge clk) begin
        if (!imm_pending)
            imm_idx <= id_word.fields.ra;
    end

endmodule

/* fetch/fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  instr_word_u       fetch_word,
    input  logic              branch_taken,   // from EX, flushes ID
    input  logic [DATA_W-1:0] branch_target,
    output logic [DATA_W-1:0] fetch_addr,
    output instr_word_u       id_word
);

    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pc_next;

    // no stalls, so pc always advances
    assign pc_next    = branch_taken ? branch_target : pc + 1'b1;
    assign fetch_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rst_n || branch_taken)
            id_word <= NOP_WORD;  // drops the word fetched behind a taken jump
        else
            id_word <= fetch_word;
    end

endmodule

/* hdl/unified_mem.sv */
module unified_mem import cpu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] fetch_addr,
    output instr_word_u       fetch_word,
    input  logic [DATA_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    input  logic              data_we,
    output logic [DATA_W-1:0] data_rdata,
    input  logic              boot_we,
    input  logic [DATA_W-1:0] boot_addr,
    input  logic [DATA_W-1:0] boot_data
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];  // shared code and data

    logic [ADDR_W-1:0] f_idx, d_idx, w_idx;
    logic              w_en;
    logic [DATA_W-1:0] w_data;

    assign f_idx = ADDR_W'(fetch_addr % MEM_WORDS);  // wrap on small arrays
    assign d_idx = ADDR_W'(data_addr % MEM_WORDS);

    // boot loader owns the write port while the core is held in reset
    assign w_en   = rst_n ? data_we : boot_we;
    assign w_idx  = rst_n ? d_idx : ADDR_W'(boot_addr % MEM_WORDS);
    assign w_data = rst_n ? data_wdata : boot_data;

    assign fetch_word = mem[f_idx];  // async read, fetch port
    assign data_rdata = mem[d_idx];  // async read, data port

    always_ff @(posedge clk) begin
        if (w_en)
            mem[w_idx] <= w_data;
    end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

    // datapath sizes
    localparam int DATA_W    = 8;   // data and address
    localparam int REG_IDX_W = 2;   // register index
    localparam int NUM_REGS  = 4;
    localparam int OPCODE_W  = 4;
    localparam int ALU_OP_W  = 3;

    // opcodes, upper nibble of the instruction word
    localparam logic [OPCODE_W-1:0] OP_NOP = 4'h0;
    localparam logic [OPCODE_W-1:0] OP_MOV = 4'h1;  // ra <- rb
    localparam logic [OPCODE_W-1:0] OP_ADD = 4'h2;  // ra <- ra + rb
    localparam logic [OPCODE_W-1:0] OP_SUB = 4'h3;  // ra <- ra - rb
    localparam logic [OPCODE_W-1:0] OP_AND = 4'h4;
    localparam logic [OPCODE_W-1:0] OP_OR  = 4'h5;
    localparam logic [OPCODE_W-1:0] OP_NOT = 4'h6;  // ra <- ~rb
    localparam logic [OPCODE_W-1:0] OP_IN  = 4'h7;  // ra <- in_port
    localparam logic [OPCODE_W-1:0] OP_OUT = 4'h8;  // out_port <- ra
    localparam logic [OPCODE_W-1:0] OP_LDI = 4'h9;  // ra <- next word
    localparam logic [OPCODE_W-1:0] OP_LDM = 4'hA;  // ra <- mem[rb]
    localparam logic [OPCODE_W-1:0] OP_STM = 4'hB;  // mem[rb] <- ra
    localparam logic [OPCODE_W-1:0] OP_JZ  = 4'hC;  // jumps go to rb
    localparam logic [OPCODE_W-1:0] OP_JN  = 4'hD;
    localparam logic [OPCODE_W-1:0] OP_JC  = 4'hE;
    localparam logic [OPCODE_W-1:0] OP_JMP = 4'hF;

    // alu operation select
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NOT    = 3'd5;

    // branch condition
    localparam logic [2:0] BR_NONE   = 3'd0;
    localparam logic [2:0] BR_Z      = 3'd1;
    localparam logic [2:0] BR_N      = 3'd2;
    localparam logic [2:0] BR_C      = 3'd3;
    localparam logic [2:0] BR_ALWAYS = 3'd4;

    // positions in the 3-bit flag vector
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;

    // word injected into ID on reset and flush
    localparam logic [DATA_W-1:0] NOP_WORD = {OP_NOP, {(DATA_W-OPCODE_W){1'b0}}};

    // one memory word, seen as an instruction or as the LDI operand
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]  opcode;
            logic [REG_IDX_W-1:0] ra;
            logic [REG_IDX_W-1:0] rb;
        } fields;
        logic [DATA_W-1:0] imm;
    } instr_word_u;

endpackage
